//--- src/disp_pkg.sv
package disp_pkg;

    localparam int ROW_CYCLES = 1232; // clocks per display line.
    localparam int SCREEN_W   = 240;
    localparam int SCREEN_H   = 228;  // rows per frame, blanking included.
    localparam int RESET_WAIT = 3;

    // one pixel of the object layer as seen by the compositor.
    typedef struct packed {
        logic [1:0] prio;
        logic [1:0] mode;
        logic       transparent;
        logic       palette_mode; // set for 256 colours.
        logic [7:0] colour;       // bank and nibble in 16-colour mode.
    } obj_packet_t;

    localparam obj_packet_t OBJ_PACKET_CLEAR = '{
        prio:         2'd0,
        mode:         2'd0,
        transparent:  1'b1,
        palette_mode: 1'b0,
        colour:       8'd0
    };

endpackage : disp_pkg

//--- src/obj_pkg.sv
package obj_pkg;

    localparam int          OBJ_COUNT     = 128;
    localparam logic [14:0] OBJ_VRAM_BASE = 15'h4000; // object characters, in halfwords.

    // attr1 in the high half, attr0 in the low half.
    typedef struct packed {
        logic [1:0] size;
        logic       vflip;
        logic       hflip;
        logic [2:0] rsv_a1;
        logic [8:0] x;
        logic [1:0] shape;
        logic       colour256;
        logic       rsv_12;   // mosaic, not rendered.
        logic [1:0] mode;
        logic       disabled;
        logic       rsv_8;    // affine select, not rendered.
        logic [7:0] y;
    } oam_word0_t;

    typedef struct packed {
        logic [15:0] rsv_hi;  // affine parameter slot.
        logic [3:0]  bank;
        logic [1:0]  prio;
        logic [9:0]  name;
    } oam_word1_t;

    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        logic [6:0] width;
        logic [6:0] height;
        logic [9:0] name;
        logic [1:0] prio;
        logic [1:0] mode;
        logic       palette_mode;
        logic [3:0] bank;
        logic       hflip;
        logic       vflip;
        logic       enabled;
    } obj_state_t;

    // one vram halfword, 4bpp or 8bpp.
    typedef union packed {
        logic [3:0][3:0] nibbles;
        logic [1:0][7:0] bytes;
    } vram_word_u;

    typedef struct packed {
        logic [6:0] width;
        logic [6:0] height;
    } obj_dim_t;

    function automatic obj_dim_t obj_size_lookup(input logic [1:0] shape,
                                                 input logic [1:0] size);
        obj_dim_t dim;
        case ({shape, size})
            4'b00_00: dim = '{7'd8,  7'd8};
            4'b00_01: dim = '{7'd16, 7'd16};
            4'b00_10: dim = '{7'd32, 7'd32};
            4'b00_11: dim = '{7'd64, 7'd64};
            4'b01_00: dim = '{7'd16, 7'd8};  // wide.
            4'b01_01: dim = '{7'd32, 7'd8};
            4'b01_10: dim = '{7'd32, 7'd16};
            4'b01_11: dim = '{7'd64, 7'd32};
            4'b10_00: dim = '{7'd8,  7'd16}; // tall.
            4'b10_01: dim = '{7'd8,  7'd32};
            4'b10_10: dim = '{7'd16, 7'd32};
            4'b10_11: dim = '{7'd32, 7'd64};
            default:  dim = '{7'd8,  7'd8};  // shape 3 is prohibited.
        endcase
        return dim;
    endfunction

endpackage : obj_pkg

//--- src/obj_attr_fetch.sv
module obj_attr_fetch
    import obj_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        restart,
    input  logic        next_obj,
    input  logic [31:0] oam_data,
    output logic [7:0]  oam_addr,
    output obj_state_t  obj,
    output logic        attr_valid,
    output logic        scan_done
);

    typedef enum logic [2:0] {F_IDLE, F_A0, F_A1, F_CAP, F_HOLD} fetch_phase_t;

    fetch_phase_t phase;
    logic [6:0]   idx;
    oam_word0_t   w0_q;
    oam_word1_t   w1_q;
    obj_dim_t     dim;

    // hold already points at word 0 of the next object.
    always_comb begin
        case (phase)
            F_A1, F_CAP: oam_addr = {idx, 1'b1};
            F_HOLD:      oam_addr = {idx + 7'd1, 1'b0};
            default:     oam_addr = {idx, 1'b0};
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            phase      <= F_IDLE;
            idx        <= '0;
            attr_valid <= 1'b0;
            scan_done  <= 1'b0;
        end else begin
            attr_valid <= 1'b0;
            if (restart) begin
                phase     <= F_A0;
                idx       <= '0;
                scan_done <= 1'b0;
            end else begin
                case (phase)
                    F_A0:  phase <= F_A1;
                    F_A1:  phase <= F_CAP;
                    F_CAP: begin
                        phase      <= F_HOLD;
                        attr_valid <= 1'b1;
                    end
                    F_HOLD: begin
                        if (next_obj) begin
                            idx <= idx + 7'd1;
                            if (idx == 7'(OBJ_COUNT - 1)) begin
                                phase     <= F_IDLE; // last object done.
                                scan_done <= 1'b1;
                            end else begin
                                phase <= F_A1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (phase == F_A1) w0_q <= oam_data;
        if (phase == F_CAP) w1_q <= oam_data;
    end

    always_comb begin
        dim              = obj_size_lookup(w0_q.shape, w0_q.size);
        obj.x            = w0_q.x;
        obj.y            = w0_q.y;
        obj.width        = dim.width;
        obj.height       = dim.height;
        obj.name         = w1_q.name;
        obj.prio         = w1_q.prio;
        obj.mode         = w0_q.mode;
        obj.palette_mode = w0_q.colour256;
        obj.bank         = w1_q.bank;
        obj.hflip        = w0_q.hflip;
        obj.vflip        = w0_q.vflip;
        obj.enabled      = ~w0_q.disabled;
    end

endmodule : obj_attr_fetch

//--- src/obj_pixel_addr.sv
module obj_pixel_addr
    import obj_pkg::*;
    import disp_pkg::*;
(
    input  obj_state_t  obj,
    input  logic [7:0]  render_row,
    input  logic [6:0]  col_offset,
    output logic [14:0] vram_addr,
    output logic [8:0]  col,
    output logic [2:0]  px_low,
    output logic        row_hit,
    output logic        in_screen
);

    logic [7:0]  dy;
    logic [6:0]  px_full, py_full;
    logic [5:0]  px, py;
    logic [3:0]  tiles_per_row;
    logic [6:0]  tile_idx;
    logic [10:0] tile_units;
    logic [14:0] tile_base;
    logic [14:0] in_tile;

    assign dy      = render_row - obj.y; // wraps at 256.
    assign row_hit = {1'b0, dy} < {2'b00, obj.height};

    assign px_full = obj.hflip ? obj.width - 7'd1 - col_offset : col_offset;
    assign py_full = obj.vflip ? obj.height - 7'd1 - dy[6:0] : dy[6:0];
    assign px      = px_full[5:0];
    assign py      = py_full[5:0];
    assign px_low  = px[2:0];

    // 1D mapping keeps the tiles of one object in order.
    assign tiles_per_row = obj.width[6:3];
    assign tile_idx      = {4'd0, py[5:3]} * {3'd0, tiles_per_row} + {4'd0, px[5:3]};

    always_comb begin
        if (obj.palette_mode) begin
            tile_units = {1'b0, obj.name} + {3'd0, tile_idx, 1'b0}; // 64 bytes a tile.
            in_tile    = {10'd0, py[2:0], 2'b00} + {13'd0, px[2:1]};
        end else begin
            tile_units = {1'b0, obj.name} + {4'd0, tile_idx};
            in_tile    = {11'd0, py[2:0], 1'b0} + {14'd0, px[2]};
        end
    end

    assign tile_base = {tile_units, 4'b0000}; // 16 halfwords per 32 bytes.
    assign vram_addr = OBJ_VRAM_BASE + tile_base + in_tile;

    assign col       = obj.x + {2'b00, col_offset}; // wraps at 512.
    assign in_screen = col < 9'(SCREEN_W);

endmodule : obj_pixel_addr

//--- src/obj_pixel_decode.sv
module obj_pixel_decode
    import obj_pkg::*;
(
    input  vram_word_u  vram_data,
    input  logic [2:0]  px_low,
    input  logic        palette_mode,
    input  logic [3:0]  bank,
    output logic [7:0]  colour,
    output logic        transparent
);

    logic [3:0] nibble;
    logic [7:0] index;

    // leftmost pixel sits in the low bits.
    assign nibble = vram_data.nibbles[px_low[1:0]];

    always_comb begin
        if (palette_mode) begin
            index  = vram_data.bytes[px_low[0]];
            colour = index;
        end else begin
            index  = {4'd0, nibble};
            colour = {bank, nibble};
        end
    end

    assign transparent = (index == 8'd0); // index zero shows nothing.

endmodule : obj_pixel_decode

//--- src/obj_row_double_buffer.sv
module obj_row_double_buffer
    import disp_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        swap,
    input  logic        we,
    input  logic [7:0]  wcol,
    input  obj_packet_t wdata,
    input  logic [7:0]  rcol,
    output obj_packet_t rdata
);

    obj_packet_t                line_mem [2][SCREEN_W];
    logic [1:0][SCREEN_W-1:0]   opaque;
    logic                       sel;   // half being displayed.
    logic                       back;
    logic                       wr_ok;

    assign back = ~sel;

    // an opaque entry belongs to an earlier object.
    assign wr_ok = we && !swap && !wdata.transparent && (wcol < 8'(SCREEN_W))
                   && !opaque[back][wcol];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sel    <= 1'b0;
            opaque <= '0;
        end else if (swap) begin
            sel         <= ~sel;
            opaque[sel] <= '0; // old front becomes the new back.
        end else if (wr_ok) begin
            opaque[back][wcol] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_ok) line_mem[back][wcol] <= wdata;
    end

    always_comb begin
        rdata = OBJ_PACKET_CLEAR;
        if (rcol < 8'(SCREEN_W) && opaque[sel][rcol]) begin
            rdata = line_mem[sel][rcol];
        end
    end

endmodule : obj_row_double_buffer

//--- src/obj_top.sv
module obj_top
    import obj_pkg::*;
    import disp_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    output logic [7:0]  oam_addr,
    input  logic [31:0] oam_data,
    output logic [14:0] vram_addr,
    input  logic [15:0] vram_data,
    input  logic [7:0]  vcount,
    input  logic [7:0]  hcount,
    output obj_packet_t obj_packet,
    output logic        line_start
);

    typedef enum logic [1:0] {RESET, SCAN, DRAW, IDLE} ctrl_state_t;

    ctrl_state_t cs, ns;
    logic [10:0] timer;
    logic [1:0]  wait_cnt;
    logic [7:0]  render_row;
    logic [6:0]  col_offset;
    logic        next_obj, step, draw_we;

    obj_state_t  obj;
    logic        attr_valid, scan_done;
    logic [14:0] pix_addr;
    logic [8:0]  col;
    logic [2:0]  px_low;
    logic        row_hit, in_screen;

    logic [7:0]  col_q;
    logic [2:0]  px_low_q;
    logic [1:0]  prio_q, mode_q;
    logic [3:0]  bank_q;
    logic        pm_q, we_q;
    logic [7:0]  colour;
    logic        transparent;
    obj_packet_t wdata;

    assign line_start = (cs == RESET) ? (wait_cnt == 2'(RESET_WAIT - 1))
                                      : (timer == 11'(ROW_CYCLES - 1));

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            cs         <= RESET;
            timer      <= '0;
            wait_cnt   <= '0;
            render_row <= '0;
            col_offset <= '0;
            we_q       <= 1'b0;
        end else begin
            cs <= ns;
            if (cs == RESET) wait_cnt <= wait_cnt + 2'd1;
            timer <= (line_start || cs == RESET) ? '0 : timer + 11'd1;
            if (line_start) begin
                render_row <= (vcount >= 8'(SCREEN_H - 1)) ? '0 : vcount + 8'd1;
            end
            col_offset <= step ? col_offset + 7'd1 : '0;
            we_q       <= draw_we & in_screen; // off-screen columns never write.
        end
    end

    always_comb begin
        ns       = cs;
        next_obj = 1'b0;
        step     = 1'b0;
        draw_we  = 1'b0;
        case (cs)
            SCAN: begin
                if (scan_done) begin
                    ns = IDLE;
                end else if (attr_valid) begin
                    if (obj.enabled && row_hit) ns = DRAW;
                    else next_obj = 1'b1;
                end
            end
            DRAW: begin
                draw_we = 1'b1;
                if (col_offset == obj.width - 7'd1) begin
                    ns       = SCAN;
                    next_obj = 1'b1;
                end else begin
                    step = 1'b1;
                end
            end
            default: ;
        endcase
        if (line_start) begin // unfinished objects are dropped.
            ns       = SCAN;
            next_obj = 1'b0;
            step     = 1'b0;
            draw_we  = 1'b0;
        end
    end

    assign vram_addr = (cs == DRAW) ? pix_addr : '0;

    // metadata lines up with the returning vram halfword.
    always_ff @(posedge clock) begin
        col_q    <= col[7:0];
        px_low_q <= px_low;
        prio_q   <= obj.prio;
        mode_q   <= obj.mode;
        pm_q     <= obj.palette_mode;
        bank_q   <= obj.bank;
    end

    assign wdata = '{
        prio:         prio_q,
        mode:         mode_q,
        transparent:  transparent,
        palette_mode: pm_q,
        colour:       colour
    };

    obj_attr_fetch i_attr_fetch (
        .clock, .reset,
        .restart(line_start), .next_obj, .oam_data, .oam_addr,
        .obj, .attr_valid, .scan_done
    );

    obj_pixel_addr i_pixel_addr (
        .obj, .render_row, .col_offset,
        .vram_addr(pix_addr), .col, .px_low, .row_hit, .in_screen
    );

    obj_pixel_decode i_pixel_decode (
        .vram_data, .px_low(px_low_q), .palette_mode(pm_q), .bank(bank_q),
        .colour, .transparent
    );

    obj_row_double_buffer i_row_buffer (
        .clock, .reset,
        .swap(line_start), .we(we_q), .wcol(col_q), .wdata,
        .rcol(hcount), .rdata(obj_packet)
    );

endmodule : obj_top

//--- test/obj_mem_model.sv
module obj_mem_model (
    input  logic        clock,
    input  logic [7:0]  oam_addr,
    output logic [31:0] oam_data,
    input  logic [14:0] vram_addr,
    output logic [15:0] vram_data
);

    timeunit 1ns;
    timeprecision 1ns;

    logic [31:0] oam_mem  [256];
    logic [15:0] vram_mem [32768];

    initial begin
        for (int i = 0; i < 256; i++) begin
            oam_mem[i] = i[0] ? 32'h0000_0000 : 32'h0000_0200; // every object disabled.
        end
        // background and tile area never read as zero.
        for (int a = 0; a < 32768; a++) begin
            vram_mem[a] = {a[14:0], 1'b1};
        end
    end

    // one clock of read latency on both ports.
    always @(posedge clock) begin
        oam_data  <= oam_mem[oam_addr];
        vram_data <= vram_mem[vram_addr];
    end

endmodule : obj_mem_model

//--- test/obj_tb.sv
module obj_tb
    import obj_pkg::*;
    import disp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_TESTS      = 7;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 4 * ROW_CYCLES + 100;

    typedef struct packed {
        logic [6:0] idx;
        logic [8:0] x;
        logic [7:0] y;
        logic [1:0] shape;
        logic [1:0] size;
        logic       c256;
        logic       hflip;
        logic       vflip;
        logic [9:0] name;
        logic [1:0] prio;
        logic [1:0] mode;
        logic [3:0] bank;
    } obj_spec_t;

    logic        clock, reset;
    logic [7:0]  oam_addr, vcount, hcount;
    logic [31:0] oam_data;
    logic [14:0] vram_addr;
    logic [15:0] vram_data;
    obj_packet_t obj_packet;
    logic        line_start;

    string      tname [NUM_TESTS];
    obj_spec_t  spec [NUM_TESTS][4];
    int         nobj [NUM_TESTS];
    logic [7:0] row [NUM_TESTS];
    bit         expect_pixels [NUM_TESTS];

    integer seed = 22;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     pulses = 0;
    int     since_pulse = 0;
    bit     first_seen = 1'b0;

    obj_top i_obj_top (
        .clock, .reset, .oam_addr, .oam_data, .vram_addr, .vram_data,
        .vcount, .hcount, .obj_packet, .line_start
    );

    obj_mem_model i_mem (
        .clock, .oam_addr, .oam_data, .vram_addr, .vram_data
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic obj_spec_t make_obj(
        input logic [6:0] idx, input logic [8:0] x, input logic [7:0] y,
        input logic [1:0] shape, input logic [1:0] size, input logic c256,
        input logic hflip, input logic vflip, input logic [9:0] name,
        input logic [1:0] prio, input logic [1:0] mode, input logic [3:0] bank);
        obj_spec_t o;
        o = '{idx, x, y, shape, size, c256, hflip, vflip, name, prio, mode, bank};
        return o;
    endfunction

    function automatic int obj_width(input logic [1:0] shape, input logic [1:0] size);
        case (shape)
            2'd1:    return (size == 2'd0) ? 16 : (size == 2'd3) ? 64 : 32;
            2'd2:    return (size == 2'd3) ? 32 : (size == 2'd2) ? 16 : 8;
            default: return 8 << size;
        endcase
    endfunction

    // wide and tall shapes are transposes.
    function automatic int obj_height(input logic [1:0] shape, input logic [1:0] size);
        case (shape)
            2'd1:    return obj_width(2'd2, size);
            2'd2:    return obj_width(2'd1, size);
            default: return obj_width(shape, size);
        endcase
    endfunction

    task automatic describe_test(input int t, input string name, input int count,
                                 input logic [7:0] target_row, input bit pixels);
        tname[t]         = name;
        nobj[t]          = count;
        row[t]           = target_row;
        expect_pixels[t] = pixels;
    endtask

    task automatic setup_table();
        describe_test(0, "empty", 0, 8'd40, 0);
        describe_test(1, "c16_16x16", 1, 8'd57, 1);
        spec[1][0] = make_obj(3, 20, 50, 0, 1, 0, 0, 0, 8, 1, 0, 5);
        describe_test(2, "c16_off_row", 1, 8'd70, 0);
        spec[2][0] = spec[1][0];
        describe_test(3, "flip_hv", 1, 8'd105, 1);
        spec[3][0] = make_obj(0, 60, 100, 1, 2, 0, 1, 1, 40, 3, 0, 9);
        describe_test(4, "c256_32x8", 1, 8'd27, 1);
        spec[4][0] = make_obj(10, 100, 20, 1, 1, 1, 0, 0, 100, 2, 1, 0);
        describe_test(5, "overlap", 2, 8'd35, 1);
        spec[5][0] = make_obj(7, 58, 26, 0, 1, 0, 0, 0, 20, 0, 0, 3); // higher index first.
        spec[5][1] = make_obj(2, 50, 30, 0, 1, 0, 0, 0, 12, 1, 0, 11);
        describe_test(6, "clip_wrap", 2, 8'd85, 1);
        spec[6][0] = make_obj(1, 230, 80, 0, 3, 0, 0, 0, 60, 0, 0, 2); // runs past column 255.
        spec[6][1] = make_obj(4, 505, 78, 0, 1, 0, 1, 0, 70, 0, 0, 6);
    endtask

    task automatic load_test(input int t);
        obj_spec_t  o;
        oam_word0_t w0;
        oam_word0_t off;
        oam_word1_t w1;
        integer     r;
        off = '0;
        off.disabled = 1'b1;
        for (int i = 0; i < OBJ_COUNT; i++) begin
            i_mem.oam_mem[2 * i]     = off;
            i_mem.oam_mem[2 * i + 1] = '0;
        end
        for (int j = 0; j < nobj[t]; j++) begin
            o = spec[t][j];
            w0 = '0;
            w1 = '0;
            w0.y         = o.y;
            w0.x         = o.x;
            w0.shape     = o.shape;
            w0.size      = o.size;
            w0.mode      = o.mode;
            w0.colour256 = o.c256;
            w0.hflip     = o.hflip;
            w0.vflip     = o.vflip;
            w1.name      = o.name;
            w1.prio      = o.prio;
            w1.bank      = o.bank;
            i_mem.oam_mem[2 * int'(o.idx)]     = w0;
            i_mem.oam_mem[2 * int'(o.idx) + 1] = w1;
        end
        for (int a = 'h4000; a < 'h8000; a++) begin
            r = $random(seed);
            i_mem.vram_mem[a] = r[15:0] & r[31:16]; // roughly a third of nibbles clear.
        end
    endtask

    function automatic obj_packet_t expected_packet(input int t, input int c);
        obj_packet_t pkt;
        obj_spec_t   o;
        int          best, w, h, dx, dy, px, py, tile, addr;
        logic [15:0] hw;
        logic [7:0]  ci;
        pkt  = '{prio: 2'd0, mode: 2'd0, transparent: 1'b1, palette_mode: 1'b0, colour: 8'd0};
        best = OBJ_COUNT;
        for (int j = 0; j < nobj[t]; j++) begin
            o  = spec[t][j];
            w  = obj_width(o.shape, o.size);
            h  = obj_height(o.shape, o.size);
            dx = (c - int'(o.x)) & 511;
            dy = (int'(row[t]) - int'(o.y)) & 255;
            if (dx < w && dy < h && int'(o.idx) < best) begin
                px   = o.hflip ? w - 1 - dx : dx;
                py   = o.vflip ? h - 1 - dy : dy;
                tile = (py / 8) * (w / 8) + px / 8;
                if (o.c256) begin
                    addr = 'h4000 + (int'(o.name) + 2 * tile) * 16 + (py % 8) * 4 + (px % 8) / 2;
                    hw   = i_mem.vram_mem[addr & 'h7fff];
                    ci   = (px % 2 == 1) ? hw[15:8] : hw[7:0];
                end else begin
                    addr = 'h4000 + (int'(o.name) + tile) * 16 + (py % 8) * 2 + (px % 8) / 4;
                    hw   = i_mem.vram_mem[addr & 'h7fff];
                    ci   = {4'd0, 4'(hw >> (4 * (px % 4)))};
                end
                if (ci != 8'd0) begin
                    best             = int'(o.idx);
                    pkt.prio         = o.prio;
                    pkt.mode         = o.mode;
                    pkt.transparent  = 1'b0;
                    pkt.palette_mode = o.c256;
                    pkt.colour       = o.c256 ? ci : {o.bank, ci[3:0]};
                end
            end
        end
        return pkt;
    endfunction

    task automatic check_packet(input string name, input int col,
                                input obj_packet_t expected, input obj_packet_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s col %0d: expected %h actual %h", name, col, expected, actual);
        end
    endtask

    task automatic check_pulse(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %s: expected %0d cycles actual %0d", name, expected, actual);
        end
    endtask

    task automatic wait_line_start();
        @(negedge clock);
        while (!line_start) @(negedge clock);
    endtask

    // line_start spacing counted on falling edges.
    always @(negedge clock) begin
        if (reset) begin
            since_pulse = 0;
            first_seen  = 1'b0;
        end else begin
            since_pulse++;
            if (line_start) begin
                if (first_seen) check_pulse("line_spacing", ROW_CYCLES, since_pulse);
                else check_pulse("first_line", RESET_WAIT, since_pulse);
                first_seen  = 1'b1;
                since_pulse = 0;
                pulses++;
            end
        end
    end

    initial begin
        obj_packet_t exp;
        obj_packet_t clear;
        int          bad;
        int          opaque;
        reset  = 1'b1;
        vcount = '0;
        hcount = '0;
        clear  = '{prio: 2'd0, mode: 2'd0, transparent: 1'b1, palette_mode: 1'b0, colour: 8'd0};
        setup_table();
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
            if (i == 7) reset <= 1'b0;
            hcount <= 8'(i * 29);
            @(negedge clock);
            check_packet("reset", int'(hcount), clear, obj_packet);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            load_test(t);
            bad    = errors;
            opaque = 0;
            wait_line_start();
            @(posedge clock);
            vcount <= (row[t] == 8'd0) ? 8'(SCREEN_H - 1) : row[t] - 8'd1;
            wait_line_start(); // row renders into the back half.
            wait_line_start(); // and is now on display.
            for (int c = 0; c < SCREEN_W; c++) begin
                @(posedge clock);
                hcount <= 8'(c);
                @(negedge clock);
                exp = expected_packet(t, c);
                if (!exp.transparent) opaque++;
                check_packet(tname[t], c, exp, obj_packet);
            end
            if ((opaque != 0) != expect_pixels[t]) begin
                errors++;
                $display("test %s: reference row has %0d opaque pixels, not what the test needs",
                         tname[t], opaque);
            end
            $display("test %-12s row %0d: %0d opaque, %0d errors",
                     tname[t], row[t], opaque, errors - bad);
        end
        $display("tests %0d, checks %0d, line pulses %0d, errors %0d",
                 NUM_TESTS, checks, pulses, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule : obj_tb

//--- build.f
src/disp_pkg.sv
src/obj_pkg.sv
src/obj_attr_fetch.sv
src/obj_pixel_addr.sv
src/obj_pixel_decode.sv
src/obj_row_double_buffer.sv
src/obj_top.sv
test/obj_mem_model.sv
test/obj_tb.sv

//--- Bender.yml
package:
  name: obj_layer

sources:
  - files:
      - src/disp_pkg.sv
      - src/obj_pkg.sv
      - src/obj_attr_fetch.sv
      - src/obj_pixel_addr.sv
      - src/obj_pixel_decode.sv
      - src/obj_row_double_buffer.sv
      - src/obj_top.sv
  - target: test
    files:
      - test/obj_mem_model.sv
      - test/obj_tb.sv
